/* logic/alu_ft_pkg.sv */
// Shared widths, lane count and opcode encoding
// Fault counter width and permanent-fault threshold
package alu_ft_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  // Width of operands and results
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Lane redundancy
  ////////////////////////////////////////////////////////////////////////////

  // Four identical lanes, three of them voted at a time
  localparam int N_LANES = 4;

  // Index of a single lane
  typedef logic [$clog2(N_LANES)-1:0] lane_idx_t;
  // One bit per lane
  typedef logic [N_LANES-1:0] lane_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  // The last three are compares and also drive the branch flag
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_SLT  = 3'd5,
    OP_SLTU = 3'd6,
    OP_EQ   = 3'd7
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Fault counting
  ////////////////////////////////////////////////////////////////////////////

  // Disagreement counter width, saturates at all ones
  localparam int FCNT_W = 8;

  // Count at which a lane is treated as permanently broken
  localparam int FAULT_THRESH = 4;

  typedef logic [FCNT_W-1:0] fcnt_t;

endpackage

/* logic/majority3.sv */
// Three-input majority voter for any payload type
// Also flags which inputs differ from the voted value
`timescale 1ns/1ps

module majority3 #(
  parameter type vote_t = logic
) (
  input  vote_t      a_i,
  input  vote_t      b_i,
  input  vote_t      c_i,
  output vote_t      voted_o,
  output logic [2:0] mismatch_o,
  output logic       none_agree_o
);

  logic ab_eq;
  logic ac_eq;
  logic bc_eq;

  assign ab_eq = (a_i == b_i);
  assign ac_eq = (a_i == c_i);
  assign bc_eq = (b_i == c_i);

  // Fall back to the first input when all three differ
  always_comb begin
    if (ab_eq || ac_eq) begin
      voted_o = a_i;
    end else if (bc_eq) begin
      voted_o = b_i;
    end else begin
      voted_o = a_i;
    end
  end

  // Per-input disagreement with the output
  assign mismatch_o[0] = (a_i != voted_o);
  assign mismatch_o[1] = (b_i != voted_o);
  assign mismatch_o[2] = (c_i != voted_o);

  assign none_agree_o = !ab_eq && !ac_eq && !bc_eq;

endmodule

/* logic/ft_dispatch.sv */
// Four-phase request front end
// Latches one operation and issues it to every lane at once
`timescale 1ns/1ps

module ft_dispatch (
  input  logic                   clk,
  input  logic                   rst_n,
  // Requester side
  input  logic                   req_i,
  input  alu_ft_pkg::alu_op_e    op_i,
  input  alu_ft_pkg::word_t      operand_a_i,
  input  alu_ft_pkg::word_t      operand_b_i,
  input  alu_ft_pkg::lane_mask_t lane_en_i,
  // Completion level from the vote stage
  input  logic                   done_i,
  // Lane side
  output logic                   issue_o,
  output alu_ft_pkg::alu_op_e    op_o,
  output alu_ft_pkg::word_t      operand_a_o,
  output alu_ft_pkg::word_t      operand_b_o,
  output alu_ft_pkg::lane_mask_t lane_en_o
);

  typedef enum logic {
    S_IDLE,
    S_BUSY
  } state_e;

  state_e state_q;
  // Set once ack has been seen high in this transaction
  logic   done_seen_q;
  logic   capture;

  // Take a request only while idle
  assign capture = (state_q == S_IDLE) && req_i;

  // Control state and issue pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= S_IDLE;
      done_seen_q <= 1'b0;
      issue_o     <= 1'b0;
      lane_en_o   <= '0;
    end else begin
      // Issue lasts a single cycle
      issue_o <= capture;
      if (capture) begin
        state_q     <= S_BUSY;
        done_seen_q <= 1'b0;
        lane_en_o   <= lane_en_i;
      end else if (state_q == S_BUSY) begin
        if (done_i) begin
          done_seen_q <= 1'b1;
        end else if (done_seen_q) begin
          // Ack has fallen so the handshake is closed
          state_q <= S_IDLE;
        end
      end
    end
  end

  // Operation and operands held for the lanes
  always_ff @(posedge clk) begin
    if (capture) begin
      op_o        <= op_i;
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
    end
  end

endmodule

/* logic/alu_lane.sv */
// One registered integer ALU lane with a register enable
`timescale 1ns/1ps

module alu_lane (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue_i,
  // Stands in for a per-lane clock enable
  input  logic                en_i,
  input  alu_ft_pkg::alu_op_e op_i,
  input  alu_ft_pkg::word_t   operand_a_i,
  input  alu_ft_pkg::word_t   operand_b_i,
  output alu_ft_pkg::word_t   result_o,
  output logic                cmp_o,
  output logic                valid_o
);

  import alu_ft_pkg::*;

  word_t result_d;
  logic  cmp_d;

  // Combinational operation decode
  always_comb begin
    result_d = '0;
    cmp_d    = 1'b0;
    case (op_i)
      OP_ADD:  result_d = operand_a_i + operand_b_i;
      OP_SUB:  result_d = operand_a_i - operand_b_i;
      OP_AND:  result_d = operand_a_i & operand_b_i;
      OP_OR:   result_d = operand_a_i | operand_b_i;
      OP_XOR:  result_d = operand_a_i ^ operand_b_i;
      OP_SLT:  cmp_d = $signed(operand_a_i) < $signed(operand_b_i);
      OP_SLTU: cmp_d = operand_a_i < operand_b_i;
      OP_EQ:   cmp_d = operand_a_i == operand_b_i;
      default: cmp_d = 1'b0;
    endcase
    // Compares put their flag in bit 0 of the result
    if (op_i inside {OP_SLT, OP_SLTU, OP_EQ}) begin
      result_d = word_t'(cmp_d);
    end
  end

  // A disabled lane keeps its stale result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_o <= '0;
      cmp_o    <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      // Valid pulses whether or not the lane was enabled
      valid_o <= issue_i;
      if (issue_i && en_i) begin
        result_o <= result_d;
        cmp_o    <= cmp_d;
      end
    end
  end

endmodule

/* logic/lane_vote.sv */
// Lane selection, word and flag majority vote, error classification
// Registered outcome and the ack side of the handshake
`timescale 1ns/1ps

module lane_vote (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid_i,
  input  alu_ft_pkg::word_t              results_i [alu_ft_pkg::N_LANES],
  input  logic [alu_ft_pkg::N_LANES-1:0] cmps_i,
  input  alu_ft_pkg::lane_idx_t          excl_lane_i,
  // Request level used to release ack
  input  logic                           req_i,
  output logic                           ack_o,
  output alu_ft_pkg::word_t              result_o,
  output logic                           branch_o,
  output logic                           err_detected_o,
  output logic                           err_corrected_o,
  output alu_ft_pkg::lane_mask_t         disagree_o,
  output logic                           vote_o
);

  import alu_ft_pkg::*;

  lane_idx_t  sel [3];
  word_t      sel_word [3];
  logic [2:0] sel_cmp;
  word_t      voted_word;
  logic       voted_cmp;
  logic [2:0] word_mm;
  logic [2:0] cmp_mm;
  logic [2:0] lane_mm;
  lane_mask_t disagree_d;
  logic       single_mm;

  // Skip the excluded lane and keep ascending order
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      sel[k]      = (lane_idx_t'(k) >= excl_lane_i) ? lane_idx_t'(k + 1) : lane_idx_t'(k);
      sel_word[k] = results_i[sel[k]];
      sel_cmp[k]  = cmps_i[sel[k]];
    end
  end

  majority3 #(.vote_t(word_t)) word_vote_i (
    .a_i          (sel_word[0]),
    .b_i          (sel_word[1]),
    .c_i          (sel_word[2]),
    .voted_o      (voted_word),
    .mismatch_o   (word_mm),
    .none_agree_o ()
  );

  majority3 #(.vote_t(logic)) cmp_vote_i (
    .a_i          (sel_cmp[0]),
    .b_i          (sel_cmp[1]),
    .c_i          (sel_cmp[2]),
    .voted_o      (voted_cmp),
    .mismatch_o   (cmp_mm),
    .none_agree_o ()
  );

  // A lane disagrees on either its word or its flag
  assign lane_mm = word_mm | cmp_mm;

  // Map voter slots back onto physical lanes
  always_comb begin
    disagree_d = '0;
    for (int k = 0; k < 3; k++) begin
      disagree_d[sel[k]] = lane_mm[k];
    end
  end

  // Exactly one bad lane among the three can be outvoted
  assign single_mm = (lane_mm == 3'b001) || (lane_mm == 3'b010) || (lane_mm == 3'b100);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_o           <= 1'b0;
      vote_o          <= 1'b0;
      err_detected_o  <= 1'b0;
      err_corrected_o <= 1'b0;
      disagree_o      <= '0;
    end else begin
      // Counter update strobe
      vote_o <= valid_i;
      if (valid_i) begin
        ack_o           <= 1'b1;
        err_detected_o  <= |lane_mm;
        err_corrected_o <= single_mm;
        disagree_o      <= disagree_d;
      end else if (ack_o && !req_i) begin
        // Requester has let go of req
        ack_o <= 1'b0;
      end
    end
  end

  // Voted payload held until the next operation
  always_ff @(posedge clk) begin
    if (valid_i) begin
      result_o <= voted_word;
      branch_o <= voted_cmp;
    end
  end

endmodule

/* logic/fault_monitor.sv */
// Per-lane saturating disagreement counters
// Permanent-fault flags and a combinational counter read port
`timescale 1ns/1ps

module fault_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  // One pulse per voted operation
  input  logic                   vote_i,
  input  alu_ft_pkg::lane_mask_t disagree_i,
  // Read port
  input  alu_ft_pkg::lane_idx_t  fault_rd_lane_i,
  output alu_ft_pkg::fcnt_t      fault_rd_cnt_o,
  output alu_ft_pkg::lane_mask_t permanent_faulty_o
);

  import alu_ft_pkg::*;

  fcnt_t cnt_q [N_LANES];

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int l = 0; l < N_LANES; l++) begin
        cnt_q[l] <= '0;
      end
    end else if (vote_i) begin
      for (int l = 0; l < N_LANES; l++) begin
        // Stop at all ones
        if (disagree_i[l] && (cnt_q[l] != '1)) begin
          cnt_q[l] <= cnt_q[l] + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flags and read port
  ////////////////////////////////////////////////////////////////////////////

  // Counters never decrease so the flag is sticky until reset
  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      permanent_faulty_o[l] = (cnt_q[l] >= fcnt_t'(FAULT_THRESH));
    end
  end

  // Read back the selected lane
  assign fault_rd_cnt_o = cnt_q[fault_rd_lane_i];

endmodule

/* logic/alu_ft_top.sv */
// Top level of the redundant ALU execute unit
// Dispatcher, four ALU lanes, vote stage and fault monitor
`timescale 1ns/1ps

module alu_ft_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Four-phase request
  input  logic                   req_i,
  input  alu_ft_pkg::alu_op_e    op_i,
  input  alu_ft_pkg::word_t      operand_a_i,
  input  alu_ft_pkg::word_t      operand_b_i,
  // Lane control
  input  alu_ft_pkg::lane_mask_t lane_en_i,
  input  alu_ft_pkg::lane_idx_t  excl_lane_i,
  // Response
  output logic                   ack_o,
  output alu_ft_pkg::word_t      result_o,
  output logic                   branch_o,
  output logic                   err_detected_o,
  output logic                   err_corrected_o,
  // Fault counters
  input  alu_ft_pkg::lane_idx_t  fault_rd_lane_i,
  output alu_ft_pkg::fcnt_t      fault_rd_cnt_o,
  output alu_ft_pkg::lane_mask_t permanent_faulty_o
);

  import alu_ft_pkg::*;

  // Dispatcher to lanes
  logic               issue;
  alu_op_e            op_q;
  word_t              operand_a_q;
  word_t              operand_b_q;
  lane_mask_t         lane_en_q;

  // Lanes to vote stage
  word_t              lane_result [N_LANES];
  logic [N_LANES-1:0] lane_cmp;
  logic [N_LANES-1:0] lane_valid;

  // Vote stage to monitor
  lane_mask_t         disagree;
  logic               vote_pulse;

  ////////////////////////////////////////////////////////////////////////////
  // Front end
  ////////////////////////////////////////////////////////////////////////////

  // Ack doubles as the done level
  ft_dispatch dispatch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .lane_en_i   (lane_en_i),
    .done_i      (ack_o),
    .issue_o     (issue),
    .op_o        (op_q),
    .operand_a_o (operand_a_q),
    .operand_b_o (operand_b_q),
    .lane_en_o   (lane_en_q)
  );

  // All lanes see the same operation
  for (genvar g = 0; g < N_LANES; g++) begin : g_lane
    alu_lane lane_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_i     (issue),
      .en_i        (lane_en_q[g]),
      .op_i        (op_q),
      .operand_a_i (operand_a_q),
      .operand_b_i (operand_b_q),
      .result_o    (lane_result[g]),
      .cmp_o       (lane_cmp[g]),
      .valid_o     (lane_valid[g])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Voting and fault tracking
  ////////////////////////////////////////////////////////////////////////////

  // Lanes are issued together so lane 0 times the vote
  lane_vote vote_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_i         (lane_valid[0]),
    .results_i       (lane_result),
    .cmps_i          (lane_cmp),
    .excl_lane_i     (excl_lane_i),
    .req_i           (req_i),
    .ack_o           (ack_o),
    .result_o        (result_o),
    .branch_o        (branch_o),
    .err_detected_o  (err_detected_o),
    .err_corrected_o (err_corrected_o),
    .disagree_o      (disagree),
    .vote_o          (vote_pulse)
  );

  fault_monitor monitor_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .vote_i             (vote_pulse),
    .disagree_i         (disagree),
    .fault_rd_lane_i    (fault_rd_lane_i),
    .fault_rd_cnt_o     (fault_rd_cnt_o),
    .permanent_faulty_o (permanent_faulty_o)
  );

endmodule

/* tb/alu_ft_assert.sv */
// Bound checker with a lane-level reference model built from top-level ports
// Concurrent checks on voted results, error flags, handshake timing and counters
`timescale 1ns/1ps

module alu_ft_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   req_i,
  input alu_ft_pkg::alu_op_e    op_i,
  input alu_ft_pkg::word_t      operand_a_i,
  input alu_ft_pkg::word_t      operand_b_i,
  input alu_ft_pkg::lane_mask_t lane_en_i,
  input alu_ft_pkg::lane_idx_t  excl_lane_i,
  input logic                   ack_o,
  input alu_ft_pkg::word_t      result_o,
  input logic                   branch_o,
  input logic                   err_detected_o,
  input logic                   err_corrected_o,
  input alu_ft_pkg::lane_idx_t  fault_rd_lane_i,
  input alu_ft_pkg::fcnt_t      fault_rd_cnt_o,
  input alu_ft_pkg::lane_mask_t permanent_faulty_o
);

  import alu_ft_pkg::*;

  // Number of failed checks, watched by the testbench
  int                 fail_cnt = 0;

  // Model lane contents, stale when a lane was disabled at issue
  word_t              m_word [N_LANES];
  logic [N_LANES-1:0] m_cmp;
  fcnt_t              m_cnt [N_LANES];
  logic               busy_m;
  logic               ack_seen_m;
  logic               ack_q;
  logic               cap_m;
  word_t              new_word;
  logic               new_cmp;
  lane_idx_t          sel [3];
  word_t              exp_word;
  logic               exp_cmp;
  logic [2:0]         bad;
  lane_mask_t         bad_mask;
  lane_mask_t         exp_faulty;
  fcnt_t              exp_cnt;

  // Operation rule, compares give 0 or 1
  function automatic word_t op_rule(alu_op_e op, word_t a, word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return word_t'($signed(a) < $signed(b));
      OP_SLTU: return word_t'(a < b);
      default: return word_t'(a == b);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    new_word = op_rule(op_i, operand_a_i, operand_b_i);
    new_cmp  = (op_i >= OP_SLT) && new_word[0];
    // Idle request with ack low opens a transaction
    cap_m    = req_i && !ack_o && !busy_m;
    for (int k = 0; k < 3; k++) begin
      sel[k] = (k < int'(excl_lane_i)) ? lane_idx_t'(k) : lane_idx_t'(k + 1);
    end
    // Second and third agree against the first, else the first wins
    if ((m_word[sel[1]] == m_word[sel[2]]) && (m_word[sel[0]] != m_word[sel[1]])) begin
      exp_word = m_word[sel[1]];
    end else begin
      exp_word = m_word[sel[0]];
    end
    if ((m_cmp[sel[1]] == m_cmp[sel[2]]) && (m_cmp[sel[0]] != m_cmp[sel[1]])) begin
      exp_cmp = m_cmp[sel[1]];
    end else begin
      exp_cmp = m_cmp[sel[0]];
    end
    bad_mask = '0;
    for (int k = 0; k < 3; k++) begin
      bad[k]           = (m_word[sel[k]] != exp_word) || (m_cmp[sel[k]] != exp_cmp);
      bad_mask[sel[k]] = bad[k];
    end
    for (int l = 0; l < N_LANES; l++) begin
      exp_faulty[l] = (m_cnt[l] >= fcnt_t'(FAULT_THRESH));
    end
    exp_cnt = m_cnt[fault_rd_lane_i];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_m     <= 1'b0;
      ack_seen_m <= 1'b0;
      ack_q      <= 1'b0;
      m_cmp      <= '0;
      for (int l = 0; l < N_LANES; l++) begin
        m_word[l] <= '0;
        m_cnt[l]  <= '0;
      end
    end else begin
      ack_q <= ack_o;
      if (cap_m) begin
        busy_m     <= 1'b1;
        ack_seen_m <= 1'b0;
        for (int l = 0; l < N_LANES; l++) begin
          if (lane_en_i[l]) begin
            m_word[l] <= new_word;
            m_cmp[l]  <= new_cmp;
          end
        end
      end else if (ack_o) begin
        ack_seen_m <= 1'b1;
      end else if (ack_seen_m) begin
        busy_m <= 1'b0;
      end
      // Counters move one edge after ack rises
      if (ack_o && !ack_q) begin
        for (int l = 0; l < N_LANES; l++) begin
          if (bad_mask[l] && (m_cnt[l] != '1)) begin
            m_cnt[l] <= m_cnt[l] + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> (result_o == exp_word))
    else begin
      fail_cnt++;
      $error("ERR result: expected %h, actual %h", $sampled(exp_word), $sampled(result_o));
    end

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> (branch_o == exp_cmp))
    else begin
      fail_cnt++;
      $error("ERR branch: expected %b, actual %b", $sampled(exp_cmp), $sampled(branch_o));
    end

  a_detected: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> (err_detected_o == (|bad)))
    else begin
      fail_cnt++;
      $error("ERR err_detected: expected %b, actual %b", $sampled(|bad),
             $sampled(err_detected_o));
    end

  a_corrected: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> (err_corrected_o == $onehot(bad)))
    else begin
      fail_cnt++;
      $error("ERR err_corrected: expected %b, actual %b", $sampled($onehot(bad)),
             $sampled(err_corrected_o));
    end

  a_fault_cnt: assert property (@(posedge clk) disable iff (!rst_n)
    fault_rd_cnt_o == exp_cnt)
    else begin
      fail_cnt++;
      $error("ERR fault_cnt: expected %0d, actual %0d", $sampled(exp_cnt),
             $sampled(fault_rd_cnt_o));
    end

  a_faulty: assert property (@(posedge clk) disable iff (!rst_n)
    permanent_faulty_o == exp_faulty)
    else begin
      fail_cnt++;
      $error("ERR permanent_faulty: expected %b, actual %b", $sampled(exp_faulty),
             $sampled(permanent_faulty_o));
    end

  // Handshake timing
  a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    cap_m |=> !ack_o ##1 !ack_o ##1 ack_o)
    else begin
      fail_cnt++;
      $error("Handshake: ack_o did not rise on the third edge after capture");
    end

  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ack_o && req_i) |=> ack_o)
    else begin
      fail_cnt++;
      $error("Handshake: ack_o dropped while req_i was still high");
    end

  a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    (ack_o && !req_i) |=> !ack_o)
    else begin
      fail_cnt++;
      $error("Handshake: ack_o stayed high one edge after req_i fell");
    end

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> (!ack_o && !err_detected_o && !err_corrected_o &&
                      (permanent_faulty_o == '0) && (fault_rd_cnt_o == '0)))
    else begin
      fail_cnt++;
      $error("Reset: ack, error flags or fault counters were not cleared");
    end

endmodule

bind alu_ft_top alu_ft_assert alu_ft_assert_i (.*);

/* tb/alu_ft_tb.sv */
// Testbench for the redundant ALU execute unit
// Seeded random and directed four-phase transactions, watchdog and final verdict
`timescale 1ns/1ps

module alu_ft_tb;

  import alu_ft_pkg::*;

  localparam int N_RANDOM        = 40;
  localparam int N_DIRECT        = 4;
  localparam int N_STUCK         = 270;
  localparam int N_MIXED         = 40;
  localparam int N_AFTER         = 4;
  localparam int N_TRANS         = N_RANDOM + N_DIRECT + N_STUCK + N_MIXED + N_AFTER;
  localparam int RESET_CYCLES    = 4;
  localparam int WATCHDOG_CYCLES = N_TRANS * 12 + 2 * RESET_CYCLES;

  logic       clk;
  logic       rst_n;
  logic       req;
  alu_op_e    op;
  word_t      opa;
  word_t      opb;
  lane_mask_t lane_en;
  lane_idx_t  excl_lane;
  lane_idx_t  rd_lane;
  logic       ack;
  word_t      result;
  logic       branch;
  logic       err_det;
  logic       err_cor;
  fcnt_t      rd_cnt;
  lane_mask_t perm;
  integer     seed;

  alu_ft_top alu_ft_top_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_i              (req),
    .op_i               (op),
    .operand_a_i        (opa),
    .operand_b_i        (opb),
    .lane_en_i          (lane_en),
    .excl_lane_i        (excl_lane),
    .ack_o              (ack),
    .result_o           (result),
    .branch_o           (branch),
    .err_detected_o     (err_det),
    .err_corrected_o    (err_cor),
    .fault_rd_lane_i    (rd_lane),
    .fault_rd_cnt_o     (rd_cnt),
    .permanent_faulty_o (perm)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Full four-phase handshake, lane controls held for the whole transaction
  task automatic run_txn(input alu_op_e t_op, input word_t a, input word_t b,
                         input lane_mask_t en, input lane_idx_t excl, input lane_idx_t rd);
    int hold;
    hold = $unsigned($random(seed)) % 3;
    @(posedge clk);
    req       <= 1'b1;
    op        <= t_op;
    opa       <= a;
    opb       <= b;
    lane_en   <= en;
    excl_lane <= excl;
    rd_lane   <= rd;
    do begin
      @(posedge clk);
    end while (!ack);
    // Requester may keep req up for a while
    repeat (hold) @(posedge clk);
    req <= 1'b0;
    do begin
      @(posedge clk);
    end while (ack);
  endtask

  // Random op, equal or inverted operands now and then so compares go both ways
  task automatic run_random(input lane_mask_t en, input lane_idx_t excl, input lane_idx_t rd);
    logic [31:0] rnd;
    word_t       a;
    word_t       b;
    rnd = $random(seed);
    a   = $random(seed);
    b   = $random(seed);
    if (rnd[4:3] == 2'd0) begin
      b = a;
    end else if (rnd[4:3] == 2'd1) begin
      b = ~a;
    end
    run_txn(alu_op_e'(rnd[2:0]), a, b, en, excl, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 63319;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = 1'b0;
    op        = OP_ADD;
    opa       = '0;
    opb       = '0;
    lane_en   = '1;
    excl_lane = '0;
    rd_lane   = '0;
    apply_reset();
    // All lanes healthy
    for (int i = 0; i < N_RANDOM; i++) begin
      run_random(4'b1111, lane_idx_t'($random(seed)), lane_idx_t'($random(seed)));
    end
    // Lanes agree, then lane 1 stale and outvoted
    run_txn(OP_ADD, 32'h1111_0000, 32'h0000_2222, 4'b1111, 2'd3, 2'd1);
    run_txn(OP_SUB, 32'h8000_0000, 32'h0000_0001, 4'b1101, 2'd3, 2'd1);
    // Lanes 1 and 2 stale with different values, first selected lane wins
    run_txn(OP_XOR, 32'h0f0f_0f0f, 32'h00ff_00ff, 4'b1001, 2'd0, 2'd2);
    // Disabled lane is the excluded one
    run_txn(OP_OR, 32'h1234_0000, 32'h0000_5678, 4'b1101, 2'd1, 2'd1);
    // Lane 2 stuck until its counter saturates
    for (int i = 0; i < N_STUCK; i++) begin
      run_txn(OP_ADD, $random(seed), $random(seed), 4'b1011, 2'd3, 2'd2);
    end
    // Random enables and exclusion
    for (int i = 0; i < N_MIXED; i++) begin
      run_random(lane_mask_t'($random(seed)), lane_idx_t'($random(seed)),
                 lane_idx_t'($random(seed)));
    end
    // Second reset clears the saturated state
    apply_reset();
    for (int i = 0; i < N_AFTER; i++) begin
      run_random(4'b1111, lane_idx_t'($random(seed)), 2'd2);
    end
    repeat (3) @(posedge clk);
    if (alu_ft_top_i.alu_ft_assert_i.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "Assertion failures were recorded");
    end
  end

  // Stop at the first failed check
  initial begin
    wait (alu_ft_top_i.alu_ft_assert_i.fail_cnt != 0);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first failed assertion");
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Done: errors found");
    $fatal(1, "Timeout: transactions did not complete in the expected time");
  end

endmodule

/* compile.f */
logic/alu_ft_pkg.sv
logic/majority3.sv
logic/ft_dispatch.sv
logic/alu_lane.sv
logic/lane_vote.sv
logic/fault_monitor.sv
logic/alu_ft_top.sv
tb/alu_ft_assert.sv
tb/alu_ft_tb.sv
